// File: hw/ext_pkg.sv
`default_nettype none

package ext_pkg;

  localparam int NUM_LANES   = 4;  // Parallel execute lanes.
  localparam int LANE_W      = 2;  // Width of a lane index.
  localparam int SLOW_CYCLES = 16; // Busy length of the stalling add.

  // Opcode field, insn[2:0]. Encodings 6 and 7 are illegal.
  typedef enum logic [2:0] {
    OP_ADD3      = 3'd0, // rs0 + rs1 + imm.
    OP_ADD3_SLOW = 3'd1, // Same sum after a fixed stall.
    OP_JUMP      = 3'd2, // Target is rs0.
    OP_LOAD      = 3'd3, // Address is rs0.
    OP_STORE     = 3'd4, // Address rs0, data rs1.
    OP_TRAP      = 3'd5  // Raise an exception.
  } opcode_e;

  // Result class seen by the host.
  typedef enum logic [2:0] {
    KIND_REG    = 3'd0,
    KIND_JUMP   = 3'd1,
    KIND_MEM_LD = 3'd2,
    KIND_MEM_ST = 3'd3,
    KIND_EXC    = 3'd4
  } kind_e;

  // Request from the host.
  typedef struct packed {
    logic [31:0] insn; // Opcode [2:0], imm [15:8], tag [23:16].
    logic [31:0] rs0;  // First source operand.
    logic [31:0] rs1;  // Second source operand.
  } ext_req_t;

  // Decode to execute, flags are one-hot.
  typedef struct packed {
    logic        add;
    logic        add_slow;
    logic        jump;
    logic        load;
    logic        store;
    logic        trap;
    logic        illegal;  // Undefined opcode.
    logic [7:0]  imm;      // Zero-extended in the lane.
    logic [7:0]  tag;      // Carried through to the result.
    logic [31:0] rs0;
    logic [31:0] rs1;
  } ext_dec_t;

  // Result leaving a lane.
  typedef struct packed {
    logic [7:0]  tag;
    kind_e       kind;
    logic        reg_w;     // Register write request.
    logic [31:0] reg_wdata;
    logic [31:0] br_j_addr; // Jump target.
    logic [31:0] mem_addr;
    logic [31:0] mem_store; // Store data.
    logic        exception;
  } ext_res_t;

endpackage

`default_nettype wire

// File: hw/ext_dispatch.sv
`timescale 1ns/1ns
`default_nettype none

module ext_dispatch (
  input  logic                              CLK,
  input  logic                              nRST,
  input  logic                              in_valid,
  input  ext_pkg::ext_req_t                 in_req,
  output logic                              in_ready,
  output logic [ext_pkg::NUM_LANES-1:0]     lane_valid,
  input  logic [ext_pkg::NUM_LANES-1:0]     lane_ready,
  output ext_pkg::ext_dec_t                 lane_dec
);

  logic [ext_pkg::LANE_W-1:0] issue_ptr; // Lane that takes the next request.
  logic                       issue;     // Request transfer this cycle.

  // Handshake goes to the pointed lane only.
  assign in_ready = lane_ready[issue_ptr];
  assign issue    = in_valid && in_ready;

  always_comb begin
    lane_valid            = '0;
    lane_valid[issue_ptr] = in_valid; // Others never see valid.
  end

  // Decode, purely combinational.
  always_comb begin
    lane_dec      = '0;
    lane_dec.imm  = in_req.insn[15:8];
    lane_dec.tag  = in_req.insn[23:16];
    lane_dec.rs0  = in_req.rs0;
    lane_dec.rs1  = in_req.rs1;
    case (ext_pkg::opcode_e'(in_req.insn[2:0]))
      ext_pkg::OP_ADD3:      lane_dec.add      = 1'b1;
      ext_pkg::OP_ADD3_SLOW: lane_dec.add_slow = 1'b1;
      ext_pkg::OP_JUMP:      lane_dec.jump     = 1'b1;
      ext_pkg::OP_LOAD:      lane_dec.load     = 1'b1;
      ext_pkg::OP_STORE:     lane_dec.store    = 1'b1;
      ext_pkg::OP_TRAP:      lane_dec.trap     = 1'b1;
      default:               lane_dec.illegal  = 1'b1; // Encodings 6 and 7.
    endcase
  end

  // Strict rotation over the lanes.
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      issue_ptr <= '0;
    end else if (issue) begin
      if (int'(issue_ptr) == ext_pkg::NUM_LANES - 1)
        issue_ptr <= '0; // Wrap to lane 0.
      else
        issue_ptr <= issue_ptr + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: hw/ext_execute.sv
`timescale 1ns/1ns
`default_nettype none

module ext_execute (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              dec_valid,
  input  ext_pkg::ext_dec_t dec,
  output logic              dec_ready,
  output logic              res_valid,
  output ext_pkg::ext_res_t res,
  input  logic              res_ready
);

  ext_pkg::ext_dec_t                      dec_q;       // Held instruction.
  logic                                   full;        // Lane owns an instruction.
  logic                                   busy;        // Stall counter running.
  logic [$clog2(ext_pkg::SLOW_CYCLES)-1:0] stall_count;
  logic                                   stall_done;
  logic [31:0]                            sum;

  assign dec_ready  = !full; // Accept only while empty.
  assign stall_done = (int'(stall_count) == ext_pkg::SLOW_CYCLES - 1);
  assign res_valid  = full && (!busy || stall_done);

  // Three-input add, immediate is zero-extended.
  assign sum = dec_q.rs0 + dec_q.rs1 + {24'b0, dec_q.imm};

  always_comb begin
    res     = '0; // Nothing written by default.
    res.tag = dec_q.tag;
    if (dec_q.add || dec_q.add_slow) begin
      res.kind      = ext_pkg::KIND_REG;
      res.reg_w     = 1'b1;
      res.reg_wdata = sum;
    end else if (dec_q.jump) begin
      res.kind      = ext_pkg::KIND_JUMP;
      res.br_j_addr = dec_q.rs0;
    end else if (dec_q.load || dec_q.store) begin
      res.kind      = dec_q.store ? ext_pkg::KIND_MEM_ST : ext_pkg::KIND_MEM_LD;
      res.mem_addr  = dec_q.rs0;
      res.mem_store = dec_q.rs1;
    end else if (dec_q.trap || dec_q.illegal) begin
      res.kind      = ext_pkg::KIND_EXC;
      res.exception = 1'b1; // Trap or undefined opcode.
    end
  end

  // Payload, loaded on accept.
  always_ff @(posedge CLK) begin
    if (dec_valid && dec_ready)
      dec_q <= dec;
  end

  // Occupancy and stall counter.
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      full        <= 1'b0;
      busy        <= 1'b0;
      stall_count <= '0;
    end else if (dec_valid && dec_ready) begin
      full        <= 1'b1;
      busy        <= dec.add_slow; // Only the slow add stalls.
      stall_count <= '0;
    end else if (res_valid && res_ready) begin
      full <= 1'b0; // Drained by the collector.
      busy <= 1'b0;
    end else if (busy) begin
      if (stall_done)
        busy <= 1'b0; // Result now held until drained.
      else
        stall_count <= stall_count + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: hw/ext_collect.sv
`timescale 1ns/1ns
`default_nettype none

module ext_collect (
  input  logic                          CLK,
  input  logic                          nRST,
  input  logic [ext_pkg::NUM_LANES-1:0] res_valid,
  input  ext_pkg::ext_res_t             res [ext_pkg::NUM_LANES],
  output logic [ext_pkg::NUM_LANES-1:0] res_ready,
  output logic                          out_valid,
  output ext_pkg::ext_res_t             out_res,
  input  logic                          out_ready
);

  logic [ext_pkg::LANE_W-1:0] drain_ptr; // Lane holding the oldest result.
  logic                       drain;

  // Pointed lane goes straight to the output.
  assign out_valid = res_valid[drain_ptr];
  assign out_res   = res[drain_ptr];
  assign drain     = out_valid && out_ready;

  always_comb begin
    res_ready            = '0;
    res_ready[drain_ptr] = out_ready; // Other lanes keep their results.
  end

  // Same rotation as issue, so order is restored.
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      drain_ptr <= '0;
    end else if (drain) begin
      if (int'(drain_ptr) == ext_pkg::NUM_LANES - 1)
        drain_ptr <= '0;
      else
        drain_ptr <= drain_ptr + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: hw/ext_top.sv
`timescale 1ns/1ns
`default_nettype none

module ext_top (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              in_valid,
  input  ext_pkg::ext_req_t in_req,
  output logic              in_ready,
  output logic              out_valid,
  output ext_pkg::ext_res_t out_res,
  input  logic              out_ready
);

  logic [ext_pkg::NUM_LANES-1:0] lane_valid;
  logic [ext_pkg::NUM_LANES-1:0] lane_ready;
  ext_pkg::ext_dec_t             lane_dec;  // Shared by all lanes.
  logic [ext_pkg::NUM_LANES-1:0] res_valid;
  logic [ext_pkg::NUM_LANES-1:0] res_ready;
  ext_pkg::ext_res_t             res [ext_pkg::NUM_LANES];

  ext_dispatch i_dispatch (
    .CLK        (CLK),
    .nRST       (nRST),
    .in_valid   (in_valid),
    .in_req     (in_req),
    .in_ready   (in_ready),
    .lane_valid (lane_valid),
    .lane_ready (lane_ready),
    .lane_dec   (lane_dec)
  );

  // Identical lanes.
  for (genvar i = 0; i < ext_pkg::NUM_LANES; i++) begin : g_lane
    ext_execute i_execute (
      .CLK       (CLK),
      .nRST      (nRST),
      .dec_valid (lane_valid[i]),
      .dec       (lane_dec),
      .dec_ready (lane_ready[i]),
      .res_valid (res_valid[i]),
      .res       (res[i]),
      .res_ready (res_ready[i])
    );
  end

  ext_collect i_collect (
    .CLK       (CLK),
    .nRST      (nRST),
    .res_valid (res_valid),
    .res       (res),
    .res_ready (res_ready),
    .out_valid (out_valid),
    .out_res   (out_res),
    .out_ready (out_ready)
  );

endmodule

`default_nettype wire

// File: tb/ext_checker.sv
`timescale 1ns/1ns
`default_nettype none

module ext_checker (
  input logic              CLK,
  input logic              nRST,
  input logic              in_valid,
  input ext_pkg::ext_req_t in_req,
  input logic              in_ready,
  input logic              out_valid,
  input ext_pkg::ext_res_t out_res,
  input logic              out_ready
);

  logic [31:0] cycle;              // Free-running cycle count.
  logic [31:0] accept_cycle [256]; // Acceptance cycle, by tag.
  logic        slow_tag [256];     // Tag belongs to a slow add.
  int          hold_fails  = 0;
  int          reset_fails = 0;
  int          slow_fails  = 0;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST)
      cycle <= '0;
    else
      cycle <= cycle + 32'd1;
  end

  // Record when each tag went in.
  always_ff @(posedge CLK) begin
    if (in_valid && in_ready) begin
      accept_cycle[in_req.insn[23:16]] <= cycle;
      slow_tag[in_req.insn[23:16]]     <= (in_req.insn[2:0] == ext_pkg::OP_ADD3_SLOW);
    end
  end

  // Stalled output holds still.
  a_out_hold: assert property (@(posedge CLK) disable iff (!nRST)
    out_valid && !out_ready |=> out_valid && $stable(out_res))
    else begin
      hold_fails++;
      $error("out_valid or out_res changed while out_ready was low");
    end

  a_reset_state: assert property (@(posedge CLK) !nRST |-> in_ready && !out_valid)
    else begin
      reset_fails++;
      $error("in_ready low or out_valid high during reset");
    end

  // Slow add never leaves early.
  a_slow_latency: assert property (@(posedge CLK) disable iff (!nRST)
    out_valid && out_ready && slow_tag[out_res.tag]
      |-> (cycle - accept_cycle[out_res.tag]) >= ext_pkg::SLOW_CYCLES)
    else begin
      slow_fails++;
      $error("slow add with tag %0d returned too early", out_res.tag);
    end

endmodule

bind ext_top ext_checker i_checker (.*);

`default_nettype wire

// File: tb/ext_tb.sv
`timescale 1ns/1ns
`default_nettype none

module ext_tb;

  localparam int NUM_TESTS   = 24;
  localparam int CLK_PERIOD  = 10;
  localparam int WATCHDOG_NS = NUM_TESTS * (ext_pkg::SLOW_CYCLES + 8) * CLK_PERIOD;

  logic              CLK        = 1'b0;
  logic              nRST       = 1'b1;
  logic              in_valid   = 1'b0;
  ext_pkg::ext_req_t in_req     = '0;
  logic              in_ready;
  logic              out_valid;
  ext_pkg::ext_res_t out_res;
  logic              out_ready  = 1'b1;
  logic              stall_mode = 1'b0; // Random out_ready while set.

  string             names       [NUM_TESTS];
  ext_pkg::ext_req_t reqs        [NUM_TESTS];
  logic              stall_flags [NUM_TESTS];
  ext_pkg::ext_res_t expected    [NUM_TESTS];
  int                exp_q [$];          // Test indices in issue order.
  integer            seed = 32'h151c_80a5;
  logic              in_fire  = 1'b0;    // Sampled on the falling edge.
  logic              out_fire = 1'b0;
  ext_pkg::ext_res_t out_snap = '0;
  logic              saw_full = 1'b0;    // in_ready fell under back-pressure.
  int                pass_count = 0;
  int                fail_count = 0;

  ext_top i_dut (.*);

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  // Result expected from the instruction rules.
  function automatic ext_pkg::ext_res_t model_result(input ext_pkg::ext_req_t req);
    ext_pkg::ext_res_t r;
    r     = '0;
    r.tag = req.insn[23:16];
    case (req.insn[2:0])
      ext_pkg::OP_ADD3, ext_pkg::OP_ADD3_SLOW: begin
        r.kind      = ext_pkg::KIND_REG;
        r.reg_w     = 1'b1;
        r.reg_wdata = req.rs0 + req.rs1 + 32'(req.insn[15:8]); // Wraps at 32 bits.
      end
      ext_pkg::OP_JUMP: begin
        r.kind      = ext_pkg::KIND_JUMP;
        r.br_j_addr = req.rs0; // Target is rs0.
      end
      ext_pkg::OP_LOAD, ext_pkg::OP_STORE: begin
        r.kind      = (req.insn[2:0] == ext_pkg::OP_STORE) ? ext_pkg::KIND_MEM_ST
                                                           : ext_pkg::KIND_MEM_LD;
        r.mem_addr  = req.rs0;
        r.mem_store = req.rs1;
      end
      default: begin
        r.kind      = ext_pkg::KIND_EXC; // Trap, encodings 6 and 7.
        r.exception = 1'b1;
      end
    endcase
    return r;
  endfunction

  // One table row, tag equals the row index.
  task automatic set_entry(input int idx, input string name, input logic [2:0] op,
                           input logic [7:0] imm, input logic [31:0] rs0,
                           input logic [31:0] rs1, input logic stall);
    names[idx]       = name;
    reqs[idx]        = {{8'h00, 8'(idx), imm, 5'b00000, op}, rs0, rs1};
    stall_flags[idx] = stall;
    expected[idx]    = model_result(reqs[idx]);
  endtask

  task automatic build_table();
    set_entry(0,  "add3_basic",      ext_pkg::OP_ADD3,      8'h05, 32'd10,        32'd20, 1'b0);
    set_entry(1,  "add3_imm_max",    ext_pkg::OP_ADD3,      8'hff, 32'd1,         32'd2, 1'b0);
    set_entry(2,  "add3_wrap",       ext_pkg::OP_ADD3,      8'h10, 32'hffff_fff0, 32'd1, 1'b0);
    set_entry(3,  "add3_zero",       ext_pkg::OP_ADD3,      8'h00, 32'd0,         32'd0, 1'b0);
    set_entry(4,  "add3_slow",       ext_pkg::OP_ADD3_SLOW, 8'h03, 32'h1000, 32'h2000, 1'b0);
    set_entry(5,  "add3_after_slow", ext_pkg::OP_ADD3,      8'h01, 32'd7,   32'd8, 1'b0);
    set_entry(6,  "jump",      ext_pkg::OP_JUMP,  8'h00, 32'h8000_0100, 32'h0000_dead, 1'b0);
    set_entry(7,  "load",      ext_pkg::OP_LOAD,  8'h00, 32'h2000_0040, 32'h0000_1234, 1'b0);
    set_entry(8,  "store",     ext_pkg::OP_STORE, 8'h00, 32'h2000_0044, 32'hcafe_f00d, 1'b0);
    set_entry(9,  "trap",      ext_pkg::OP_TRAP,  8'h11, 32'h0000_0005, 32'h0000_0006, 1'b0);
    set_entry(10, "illegal_6", 3'd6,              8'h22, 32'h0000_0007, 32'h0000_0008, 1'b0);
    set_entry(11, "illegal_7", 3'd7,              8'h2a, 32'h0000_0009, 32'h0000_000a, 1'b0);
    set_entry(12, "slow_wrap", ext_pkg::OP_ADD3_SLOW, 8'hff, 32'hffff_ffff, 32'hffff_ffff, 1'b0);
    // Back-pressure section, the slow adds block the drain.
    set_entry(13, "bp_slow",    ext_pkg::OP_ADD3_SLOW, 8'h40, 32'h0000_0100, 32'h0000_0200, 1'b1);
    set_entry(14, "bp_add_a",   ext_pkg::OP_ADD3,  8'h01, 32'h1111_1111, 32'h2222_2222, 1'b1);
    set_entry(15, "bp_add_b",   ext_pkg::OP_ADD3,  8'h80, 32'h7fff_ffff, 32'h0000_0001, 1'b1);
    set_entry(16, "bp_jump",    ext_pkg::OP_JUMP,  8'h00, 32'h0040_0000, 32'h0000_0000, 1'b1);
    set_entry(17, "bp_load",    ext_pkg::OP_LOAD,  8'h00, 32'h1000_0010, 32'h5555_aaaa, 1'b1);
    set_entry(18, "bp_store",   ext_pkg::OP_STORE, 8'h00, 32'h1000_0014, 32'ha5a5_5a5a, 1'b1);
    set_entry(19, "bp_slow2",   ext_pkg::OP_ADD3_SLOW, 8'h0f, 32'h0000_f000, 32'h0000_0f00, 1'b1);
    set_entry(20, "bp_add_c",   ext_pkg::OP_ADD3,  8'h33, 32'h0000_0003, 32'h0000_0004, 1'b1);
    set_entry(21, "bp_trap",    ext_pkg::OP_TRAP,  8'h00, 32'h0000_0000, 32'h0000_0000, 1'b1);
    set_entry(22, "bp_illegal", 3'd6,              8'h7e, 32'h0000_0001, 32'h0000_0002, 1'b1);
    set_entry(23, "bp_add_d",   ext_pkg::OP_ADD3,  8'hfe, 32'hffff_ff00, 32'h0000_0001, 1'b1);
  endtask

  // Handshakes sampled midway, where all signals are settled.
  always @(negedge CLK) begin
    in_fire  = in_valid && in_ready;
    out_fire = out_valid && out_ready;
    out_snap = out_res;
    if (stall_mode && in_valid && !in_ready)
      saw_full = 1'b1;
  end

  always @(posedge CLK) begin
    integer rnd;
    rnd = $random(seed);
    if (stall_mode)
      out_ready <= rnd[0]; // Random back-pressure.
    else
      out_ready <= 1'b1;
  end

  // Receiver, compares against the oldest outstanding test.
  always @(posedge CLK) begin
    int idx;
    if (out_fire) begin
      assert (exp_q.size() != 0) else begin
        fail_count++;
        $display("Result with tag %0d arrived with no request outstanding", out_snap.tag);
      end
      if (exp_q.size() != 0) begin
        idx = exp_q.pop_front();
        assert (out_snap == expected[idx]) begin
          pass_count++;
          $display("Pass %s", names[idx]);
        end else begin
          fail_count++;
          $display("Fail %s expected %h actual %h", names[idx], expected[idx], out_snap);
        end
      end
    end
  end

  initial begin
    int checker_fails;
    build_table();
    #1 nRST <= 1'b0;
    repeat (3) @(posedge CLK);
    nRST <= 1'b1;
    @(posedge CLK);
    for (int i = 0; i < NUM_TESTS; i++) begin
      in_valid   <= 1'b1;
      in_req     <= reqs[i];
      stall_mode <= stall_flags[i];
      exp_q.push_back(i);
      @(posedge CLK);
      while (!in_fire) @(posedge CLK); // Held until accepted.
    end
    in_valid   <= 1'b0;
    in_req     <= '0;
    stall_mode <= 1'b0;
    while (exp_q.size() != 0) @(posedge CLK); // Drain the lanes.
    repeat (4) @(posedge CLK); // Catch any extra result.
    assert (saw_full) else begin
      fail_count++;
      $display("in_ready never fell while all lanes were full");
    end
    checker_fails = i_dut.i_checker.hold_fails + i_dut.i_checker.reset_fails
                  + i_dut.i_checker.slow_fails;
    assert (checker_fails == 0) else begin
      fail_count++;
      $display("Handshake checker flagged %0d assertion failures", checker_fails);
    end
    $display("Results: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog.
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: run did not finish within %0d ns", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
hw/ext_pkg.sv
hw/ext_dispatch.sv
hw/ext_execute.sv
hw/ext_collect.sv
hw/ext_top.sv
tb/ext_checker.sv
tb/ext_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := ext_tb
FILELIST  := list.f
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
